//--- microPkg.sv
// Microword field types and condition codes for the condition and console block
`default_nettype none

package microPkg;

  // COND field, group in the upper three bits and item in the lower three
  typedef logic [5:0] condT;

  // Magic-number field, bits 8 down to 0
  typedef logic [8:0] magicT;

  // Bus data bits 18 to 22 seen by CONO, bit 0 is bus bit 18
  typedef logic [4:0] ebusFieldT;

  // Condition codes in the 20-27 group
  localparam condT condDiagFunc  = 6'o20;
  localparam condT condEboxState = 6'o21;

  // Skip groups
  localparam logic [2:0] condSkipA = 3'd6;
  localparam logic [2:0] condSkipB = 3'd7;

endpackage

`default_nettype wire

//--- diagPkg.sv
// Console diagnostic function codes and readback word types
`default_nettype none

package diagPkg;

  typedef logic [2:0] diagFuncT;
  typedef logic [2:0] diagSelT;
  typedef logic [6:0] diagWordT;

  // Console control functions qualified by the diagnostic strobe
  localparam diagFuncT funcClrRun   = 3'd0;
  localparam diagFuncT funcSetRun   = 3'd1;
  localparam diagFuncT funcContinue = 3'd2;

  // Readback word selects
  localparam diagSelT selParity  = 3'd0;
  localparam diagSelT selCache   = 3'd1;
  localparam diagSelT selRun     = 3'd2;
  localparam diagSelT selState   = 3'd3;
  localparam diagSelT selConoApr = 3'd4;

endpackage

`default_nettype wire

//--- condDecode.sv
// Condition field decode, CONO and state strobes, and the registered skip bit
`timescale 1ns/10ps
`default_nettype none

module condDecode (
  input  wire logic           clk,
  input  wire logic           rstN,
  input  wire microPkg::condT  cond,
  input  wire microPkg::magicT magic,
  input  wire logic [7:0]     skipTestsA,
  input  wire logic           run,
  input  wire logic           start,
  input  wire logic           intReq,
  input  wire logic           trapEn,
  input  wire logic [3:0]     ucodeState,
  output logic                conoApr,
  output logic                conoPi,
  output logic                conoPag,
  output logic                stateLoad,
  output logic                skip
);
  import microPkg::*;

  // Magic function 01x selects the CONO family, low digit picks the device
  localparam logic [2:0] conoFunc    = 3'd1;
  localparam logic [2:0] conoItemApr = 3'd4;
  localparam logic [2:0] conoItemPi  = 3'd5;
  localparam logic [2:0] conoItemPag = 3'd6;

  logic [2:0] condGroup;
  logic [2:0] condItem;
  logic       conoSel;
  logic [7:0] skipTestsB;
  logic       skipNext;

  assign condGroup = cond[5:3];
  assign condItem  = cond[2:0];

  assign conoSel = (cond == condDiagFunc) && (magic[5:3] == conoFunc);
  assign conoApr = conoSel && (magic[2:0] == conoItemApr);
  assign conoPi  = conoSel && (magic[2:0] == conoItemPi);
  assign conoPag = conoSel && (magic[2:0] == conoItemPag);

  assign stateLoad = (cond == condEboxState);

  // Internal tests, item 0 in bit 0
  assign skipTestsB = {ucodeState, trapEn, run, ~start, intReq};

  always_comb begin
    case (condGroup)
      condSkipA: skipNext = skipTestsA[condItem];
      condSkipB: skipNext = skipTestsB[condItem];
      default:   skipNext = 1'b0;
    endcase
  end

  // Address bit 10 for the next microword
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      skip <= 1'b0;
    end else begin
      skip <= skipNext;
    end
  end

endmodule

`default_nettype wire

//--- conControl.sv
// Console run and start control with synchronized strobes and interrupt request
`timescale 1ns/10ps
`default_nettype none

module conControl #(
  parameter int syncStages = 3
) (
  input  wire logic              clk,
  input  wire logic              rstN,
  input  wire logic              diagCtl,
  input  wire diagPkg::diagFuncT diagFunc,
  input  wire logic              piReady,
  output logic                   run,
  output logic                   start,
  output logic                   intReq
);
  import diagPkg::*;

  localparam int cntW = (syncStages > 1) ? $clog2(syncStages) : 1;

  typedef enum logic [1:0] {
    startIdle,
    startSync,
    startPulse
  } startStateT;

  startStateT            startState;
  logic [cntW-1:0]       syncCnt;
  logic                  setRun;
  logic                  clrRun;
  logic                  contReq;
  logic                  runReq;
  logic [syncStages-1:0] runSync;

  always_comb begin
    setRun  = 1'b0;
    clrRun  = 1'b0;
    contReq = 1'b0;
    if (diagCtl) begin
      case (diagFunc)
        funcClrRun:   clrRun = 1'b1;
        funcSetRun:   setRun = 1'b1;
        funcContinue: contReq = 1'b1;
        default:      ;
      endcase
    end
  end

  // Run request level, then the synchronizer chain
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      runReq  <= 1'b0;
      runSync <= '0;
    end else begin
      if (setRun) begin
        runReq <= 1'b1;
      end else if (clrRun) begin
        runReq <= 1'b0;
      end
      runSync[0] <= runReq;
      for (int i = 1; i < syncStages; i++) begin
        runSync[i] <= runSync[i-1];
      end
    end
  end

  assign run = runSync[syncStages-1];

  // Continue is only taken when no start is in flight
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      startState <= startIdle;
      syncCnt    <= '0;
    end else begin
      case (startState)
        startIdle: begin
          if (contReq) begin
            startState <= startSync;
            syncCnt    <= '0;
          end
        end
        startSync: begin
          if (syncCnt == cntW'(syncStages - 1)) begin
            startState <= startPulse;
          end else begin
            syncCnt <= syncCnt + cntW'(1);
          end
        end
        default: startState <= startIdle;
      endcase
    end
  end

  assign start = (startState == startPulse);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      intReq <= 1'b0;
    end else begin
      intReq <= piReady;
    end
  end

endmodule

`default_nettype wire

//--- conStatusRegs.sv
// CONO-loaded configuration flip-flops and microcode state flags
`timescale 1ns/10ps
`default_nettype none

module conStatusRegs (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               conoApr,
  input  wire logic               conoPi,
  input  wire logic               conoPag,
  input  wire logic               stateLoad,
  input  wire microPkg::ebusFieldT ebusData,
  input  wire microPkg::magicT     magic,
  output logic                    parAdr,
  output logic                    parData,
  output logic                    parDir,
  output logic                    cacheLook,
  output logic                    cacheLoad,
  output logic                    pagingEn,
  output logic                    trapEn,
  output logic [3:0]              ucodeState
);
  import microPkg::*;

  // CONO strobes are one-hot, APR lands outside this block
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      parAdr    <= 1'b0;
      parData   <= 1'b0;
      parDir    <= 1'b0;
      cacheLook <= 1'b0;
      cacheLoad <= 1'b0;
      pagingEn  <= 1'b0;
      trapEn    <= 1'b0;
    end else begin
      case ({conoApr, conoPi, conoPag})
        3'b010: begin
          parAdr  <= ebusData[0];
          parData <= ebusData[1];
          parDir  <= ebusData[2];
        end
        3'b001: begin
          cacheLook <= ebusData[0];
          cacheLoad <= ebusData[1];
          pagingEn  <= ebusData[3];
          trapEn    <= ebusData[4];
        end
        default: ;
      endcase
    end
  end

  // Pair 00 clears, 10 holds, x1 sets
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ucodeState <= '0;
    end else if (stateLoad) begin
      for (int i = 0; i < 4; i++) begin
        ucodeState[i] <= magic[2*i+1] | (magic[2*i+2] & ucodeState[i]);
      end
    end
  end

endmodule

`default_nettype wire

//--- diagReadback.sv
// Diagnostic readback multiplexer for console status
`timescale 1ns/10ps
`default_nettype none

module diagReadback (
  input  wire logic             diagRead,
  input  wire diagPkg::diagSelT diagSel,
  input  wire logic             parAdr,
  input  wire logic             parData,
  input  wire logic             parDir,
  input  wire logic             cacheLook,
  input  wire logic             cacheLoad,
  input  wire logic             pagingEn,
  input  wire logic             trapEn,
  input  wire logic             run,
  input  wire logic             start,
  input  wire logic [3:0]       ucodeState,
  input  wire logic             conoApr,
  output diagPkg::diagWordT     diagData
);
  import diagPkg::*;

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        selParity:  diagData[2:0] = {parDir, parData, parAdr};
        // Same bit positions as the CONO PAG data, bit 2 unused
        selCache:   diagData[3:0] = {pagingEn, 1'b0, cacheLoad, cacheLook};
        selRun:     diagData[2:0] = {trapEn, run, start};
        selState:   diagData[3:0] = ucodeState;
        selConoApr: diagData[0]   = conoApr;
        default:    diagData = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- conTop.sv
// Condition and console control block of the execution box
`timescale 1ns/10ps
`default_nettype none

module conTop #(
  parameter int syncStages = 3
) (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire microPkg::condT      cond,
  input  wire microPkg::magicT     magic,
  input  wire logic [7:0]         skipTestsA,
  input  wire logic               piReady,
  input  wire microPkg::ebusFieldT ebusData,
  input  wire logic               diagCtl,
  input  wire diagPkg::diagFuncT   diagFunc,
  input  wire logic               diagRead,
  input  wire diagPkg::diagSelT    diagSel,
  output logic                    run,
  output logic                    start,
  output logic                    skip,
  output diagPkg::diagWordT        diagData,
  output logic                    parAdr,
  output logic                    parData,
  output logic                    parDir,
  output logic                    cacheLook,
  output logic                    cacheLoad,
  output logic                    pagingEn,
  output logic                    trapEn,
  output logic [3:0]              ucodeState
);

  logic intReq;
  logic conoApr;
  logic conoPi;
  logic conoPag;
  logic stateLoad;

  conControl #(
    .syncStages(syncStages)
  ) uConControl (
    .clk      (clk),
    .rstN     (rstN),
    .diagCtl  (diagCtl),
    .diagFunc (diagFunc),
    .piReady  (piReady),
    .run      (run),
    .start    (start),
    .intReq   (intReq)
  );

  condDecode uCondDecode (
    .clk        (clk),
    .rstN       (rstN),
    .cond       (cond),
    .magic      (magic),
    .skipTestsA (skipTestsA),
    .run        (run),
    .start      (start),
    .intReq     (intReq),
    .trapEn     (trapEn),
    .ucodeState (ucodeState),
    .conoApr    (conoApr),
    .conoPi     (conoPi),
    .conoPag    (conoPag),
    .stateLoad  (stateLoad),
    .skip       (skip)
  );

  conStatusRegs uConStatusRegs (
    .clk        (clk),
    .rstN       (rstN),
    .conoApr    (conoApr),
    .conoPi     (conoPi),
    .conoPag    (conoPag),
    .stateLoad  (stateLoad),
    .ebusData   (ebusData),
    .magic      (magic),
    .parAdr     (parAdr),
    .parData    (parData),
    .parDir     (parDir),
    .cacheLook  (cacheLook),
    .cacheLoad  (cacheLoad),
    .pagingEn   (pagingEn),
    .trapEn     (trapEn),
    .ucodeState (ucodeState)
  );

  diagReadback uDiagReadback (
    .diagRead   (diagRead),
    .diagSel    (diagSel),
    .parAdr     (parAdr),
    .parData    (parData),
    .parDir     (parDir),
    .cacheLook  (cacheLook),
    .cacheLoad  (cacheLoad),
    .pagingEn   (pagingEn),
    .trapEn     (trapEn),
    .run        (run),
    .start      (start),
    .ucodeState (ucodeState),
    .conoApr    (conoApr),
    .diagData   (diagData)
  );

endmodule

`default_nettype wire

//--- conTb.sv
// Random-stimulus testbench for the condition and console block with a cycle model
`timescale 1ns/10ps
`default_nettype none

module conTb;
  import microPkg::*;
  import diagPkg::*;

  localparam int syncStages = 3;
  localparam int numCycles  = 4000;
  localparam int maxCycles  = numCycles + 200;

  logic       clk;
  logic       rstN;
  condT       cond;
  magicT      magic;
  logic [7:0] skipTestsA;
  logic       piReady;
  ebusFieldT  ebusData;
  logic       diagCtl;
  diagFuncT   diagFunc;
  logic       diagRead;
  diagSelT    diagSel;
  logic       run;
  logic       start;
  logic       skip;
  diagWordT   diagData;
  logic       parAdr;
  logic       parData;
  logic       parDir;
  logic       cacheLook;
  logic       cacheLoad;
  logic       pagingEn;
  logic       trapEn;
  logic [3:0] ucodeState;

  integer seed;
  int     errCount;
  int     checkCount;

  // Reference model state
  logic       expRunReq;
  logic       runDelay[$];
  logic       expRun;
  logic       expStart;
  int         expStartTimer;
  logic       expIntReq;
  logic       expSkip;
  logic       expParAdr;
  logic       expParData;
  logic       expParDir;
  logic       expCacheLook;
  logic       expCacheLoad;
  logic       expPagingEn;
  logic       expTrapEn;
  logic [3:0] expState;

  conTop #(
    .syncStages(syncStages)
  ) DUT (
    .clk        (clk),
    .rstN       (rstN),
    .cond       (cond),
    .magic      (magic),
    .skipTestsA (skipTestsA),
    .piReady    (piReady),
    .ebusData   (ebusData),
    .diagCtl    (diagCtl),
    .diagFunc   (diagFunc),
    .diagRead   (diagRead),
    .diagSel    (diagSel),
    .run        (run),
    .start      (start),
    .skip       (skip),
    .diagData   (diagData),
    .parAdr     (parAdr),
    .parData    (parData),
    .parDir     (parDir),
    .cacheLook  (cacheLook),
    .cacheLoad  (cacheLoad),
    .pagingEn   (pagingEn),
    .trapEn     (trapEn),
    .ucodeState (ucodeState)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // CONO microword for device digit dev
  function automatic logic conoMatch(input condT c, input magicT m, input logic [2:0] dev);
    conoMatch = (c == 6'o20) && (m[5:3] == 3'd1) && (m[2:0] == dev);
  endfunction

  function automatic logic skipSelect();
    logic [2:0] item;
    item = cond[2:0];
    skipSelect = 1'b0;
    if (cond[5:3] == 3'd6) begin
      skipSelect = skipTestsA[item];
    end else if (cond[5:3] == 3'd7) begin
      case (item)
        3'd0:    skipSelect = expIntReq;
        3'd1:    skipSelect = !expStart;
        3'd2:    skipSelect = expRun;
        3'd3:    skipSelect = expTrapEn;
        default: skipSelect = expState[item[1:0]];
      endcase
    end
  endfunction

  function automatic diagWordT readbackWord();
    diagWordT w;
    w = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0:    w = {4'b0000, expParDir, expParData, expParAdr};
        3'd1:    w = {3'b000, expPagingEn, 1'b0, expCacheLoad, expCacheLook};
        3'd2:    w = {4'b0000, expTrapEn, expRun, expStart};
        3'd3:    w = {3'b000, expState};
        3'd4:    w = {6'b000000, conoMatch(cond, magic, 3'd4)};
        default: w = '0;
      endcase
    end
    readbackWord = w;
  endfunction

  task automatic testFlag(input string name, input logic got, input logic want);
    checkCount++;
    if (got !== want) begin
      errCount++;
      $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, want);
    end
  endtask

  task automatic compareWord(input string name, input logic [6:0] got, input logic [6:0] want);
    checkCount++;
    if (got !== want) begin
      errCount++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic resetModel();
    expRunReq     = 1'b0;
    expRun        = 1'b0;
    expStart      = 1'b0;
    expStartTimer = 0;
    expIntReq     = 1'b0;
    expSkip       = 1'b0;
    expParAdr     = 1'b0;
    expParData    = 1'b0;
    expParDir     = 1'b0;
    expCacheLook  = 1'b0;
    expCacheLoad  = 1'b0;
    expPagingEn   = 1'b0;
    expTrapEn     = 1'b0;
    expState      = 4'b0000;
    runDelay.delete();
    for (int i = 0; i < syncStages; i++) begin
      runDelay.push_back(1'b0);
    end
  endtask

  task automatic checkOutputs();
    testFlag("run", run, expRun);
    testFlag("start", start, expStart);
    testFlag("skip", skip, expSkip);
    testFlag("parAdr", parAdr, expParAdr);
    testFlag("parData", parData, expParData);
    testFlag("parDir", parDir, expParDir);
    testFlag("cacheLook", cacheLook, expCacheLook);
    testFlag("cacheLoad", cacheLoad, expCacheLoad);
    testFlag("pagingEn", pagingEn, expPagingEn);
    testFlag("trapEn", trapEn, expTrapEn);
    compareWord("ucodeState", {3'b000, ucodeState}, {3'b000, expState});
    compareWord("diagData", diagData, readbackWord());
  endtask

  // Model step for one rising edge on the inputs held before it
  task automatic advanceModel();
    logic nextSkip;
    logic ctlSet;
    logic ctlClr;
    logic ctlCont;
    nextSkip = skipSelect();
    ctlSet   = diagCtl && (diagFunc == 3'd1);
    ctlClr   = diagCtl && (diagFunc == 3'd0);
    ctlCont  = diagCtl && (diagFunc == 3'd2);

    if (ctlSet) begin
      expRunReq = 1'b1;
    end else if (ctlClr) begin
      expRunReq = 1'b0;
    end
    // Run follows the request syncStages edges later
    runDelay.push_back(expRunReq);
    expRun = runDelay.pop_front();

    if (expStartTimer > 0) begin
      expStart = (expStartTimer == 1);
      expStartTimer--;
    end else begin
      if (ctlCont && !expStart) begin
        expStartTimer = syncStages;
      end
      expStart = 1'b0;
    end

    expIntReq = piReady;
    expSkip   = nextSkip;

    if (conoMatch(cond, magic, 3'd5)) begin
      expParAdr  = ebusData[0];
      expParData = ebusData[1];
      expParDir  = ebusData[2];
    end
    if (conoMatch(cond, magic, 3'd6)) begin
      expCacheLook = ebusData[0];
      expCacheLoad = ebusData[1];
      expPagingEn  = ebusData[3];
      expTrapEn    = ebusData[4];
    end
    if (cond == 6'o21) begin
      for (int i = 0; i < 4; i++) begin
        case ({magic[2*i+2], magic[2*i+1]})
          2'b00:   expState[i] = 1'b0;
          2'b10:   expState[i] = expState[i];
          default: expState[i] = 1'b1;
        endcase
      end
    end
  endtask

  // Cond biased toward the diag function, state update and skip groups
  task automatic driveInputs();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  dev;
    r = $random(seed);
    s = $random(seed);
    case (r[2:0])
      3'd0, 3'd1: cond = 6'o20;
      3'd2:       cond = 6'o21;
      3'd3, 3'd4: cond = {3'd6, r[5:3]};
      3'd5, 3'd6: cond = {3'd7, r[5:3]};
      default:    cond = r[8:3];
    endcase
    case (r[15:14])
      2'd0:    dev = 3'd4;
      2'd2:    dev = 3'd6;
      default: dev = 3'd5;
    endcase
    if ((cond == 6'o20) && (r[10:9] != 2'b00)) begin
      magic = {r[13:11], 3'd1, dev};
    end else begin
      magic = s[8:0];
    end
    skipTestsA = s[16:9];
    piReady    = s[17];
    ebusData   = s[22:18];
    diagCtl    = (s[24:23] == 2'b00);
    diagFunc   = {1'b0, r[17:16]};
    diagRead   = (r[19:18] != 2'b00);
    diagSel    = r[22:20];
  endtask

  initial begin
    seed       = 32'h5769_33e1;
    errCount   = 0;
    checkCount = 0;
    rstN       = 1'b0;
    cond       = '0;
    magic      = '0;
    skipTestsA = '0;
    piReady    = 1'b0;
    ebusData   = '0;
    diagCtl    = 1'b0;
    diagFunc   = '0;
    diagRead   = 1'b1;
    diagSel    = 3'd2;
    resetModel();

    repeat (16) @(posedge clk);
    @(negedge clk);
    // Everything low at the end of reset
    checkOutputs();
    rstN = 1'b1;
    driveInputs();

    // Outputs compared mid-cycle, then the next inputs go out
    for (int n = 0; n < numCycles; n++) begin
      @(posedge clk);
      advanceModel();
      @(negedge clk);
      checkOutputs();
      driveInputs();
    end

    $display("Errors: %0d in %0d checks", errCount, checkCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    for (int c = 0; c < maxCycles; c++) begin
      @(posedge clk);
    end
    $display("Timeout: the run did not finish within %0d cycles", maxCycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
microPkg.sv
diagPkg.sv
condDecode.sv
conControl.sv
conStatusRegs.sv
diagReadback.sv
conTop.sv
conTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the console control testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module conTb -o conSim; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/conSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
